// File: Makefile
# Verilator build and run of the HPS FIFO bridge testbench

TOP = tb_hps_fifo_bridge
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Result: FAILED"; \
		exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Result: FAILED, run ended without a result"; \
		exit 1; \
	else \
		echo "Result: PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: src.f
verilog/bridge_pkg.sv
verilog/display_pkg.sv
verilog/hex_digit_decoder.sv
verilog/h2f_read_sequencer.sv
verilog/f2h_write_sequencer.sv
verilog/hps_fifo_bridge_top.sv
verification/tb_hps_fifo_bridge.sv

// File: verification/fifo_bridge_tests.txt
// Word count, then that many words pushed into the HPS-to-FPGA FIFO
// Then transmit FIFO capacity, then glyphs for digits 0 to F
// Glyphs are active low, segment a in bit 0 through g in bit 6
00000008
12345678
9ABCDEF0
DEADBEEF
00FEDCBA
13579BDF
2468ACE0
FFFFFFFF
A5C3E1F7
// Transmit FIFO capacity
0000000C
// Glyphs 0 to 7
40 79 24 30 19 12 02 78
// Glyphs 8 to F, lower-case b and d
00 10 08 03 46 21 06 0E

// File: verification/tb_hps_fifo_bridge.sv
`timescale 1ns/1ps

module tb_hps_fifo_bridge;

	import bridge_pkg::*;
	import display_pkg::*;

	// Status bit positions and reply word
	localparam int          full_bit       = 0;
	localparam int          empty_bit      = 1;
	localparam logic [31:0] expected_reply = 32'h007A_FB38;
	localparam int          seed           = 32'h0240_f61b;

	logic          CLOCK_50;
	logic          rst_n;
	word_t         h2f_csr_readdata;
	word_t         h2f_readdata;
	logic          h2f_read;
	word_t         f2h_csr_readdata;
	f2h_write_t    f2h_cmd;
	hex_segments_t hex;

	// Test data from file
	logic [31:0] tests_mem [0:63];
	logic [31:0] words [0:31];
	logic [6:0]  glyph [0:15];
	int          num_words;
	int          tx_capacity;
	int          cycle_limit;

	// FIFO model state
	word_t       rx_queue [$];
	int          push_idx;
	int          gap_left;
	int          read_count;
	int          rise_cycle;
	int          display_due;
	int          tx_count;
	int          write_cycle;
	int          stream_writes;
	int          cycle_count;
	logic        read_last;
	logic        write_last;
	logic        display_pending;
	logic        stream_on;
	logic        drain_req;
	logic [31:0] expect_word;

	hps_fifo_bridge_top UUT (
		.CLOCK_50         (CLOCK_50),
		.rst_n            (rst_n),
		.h2f_csr_readdata (h2f_csr_readdata),
		.h2f_readdata     (h2f_readdata),
		.h2f_read         (h2f_read),
		.f2h_csr_readdata (f2h_csr_readdata),
		.f2h_cmd          (f2h_cmd),
		.hex              (hex)
	);

	// ==============================
	// Helpers
	// ==============================

	task automatic check_value(input logic [63:0] expected, input logic [63:0] actual,
			input string what);
		if (expected !== actual) begin
			$display("FAIL at %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "%s", reason);
	endtask

	// Digit i shows nibble i of the low 24 bits
	function automatic logic [41:0] glyphs_of(input logic [31:0] word);
		logic [41:0] pattern;
		for (int i = 0; i < 6; i++)
			pattern[7*i +: 7] = glyph[word[4*i +: 4]];
		return pattern;
	endfunction

	// 4 ns clock
	initial begin
		CLOCK_50 = 1'b0;
		forever #2 CLOCK_50 = ~CLOCK_50;
	end

	// ==============================
	// FIFO models and monitors
	// ==============================

	// Everything here runs 1 ns after the rising edge
	always @(posedge CLOCK_50) begin
		#1;
		cycle_count++;
		if (cycle_count > cycle_limit)
			fail_run("Timeout: the run did not finish within the cycle limit");
		// Read sampled at the last edge puts the head word out now
		if (read_last) begin
			h2f_readdata    = rx_queue.pop_front();
			expect_word     = words[read_count];
			display_due     = rise_cycle + 3;
			display_pending = 1'b1;
			read_count++;
		end
		if (h2f_read) begin
			if (read_last)
				fail_run("Read stayed high for more than one cycle");
			if (h2f_csr_readdata[empty_bit])
				fail_run("Read issued while the receive FIFO was empty");
			if (cycle_count - rise_cycle < 4)
				fail_run("Read pulses came less than four cycles apart");
			rise_cycle = cycle_count;
		end
		read_last = h2f_read;
		// New word on the digits
		if (display_pending && cycle_count == display_due) begin
			check_value(64'(glyphs_of(expect_word)), 64'(hex), "digits three cycles after read");
			display_pending = 1'b0;
		end
		// Transmit side drains first so no accepted write is lost
		if (drain_req) begin
			tx_count  = 0;
			drain_req = 1'b0;
		end
		if (write_last)
			tx_count++;
		if (f2h_cmd.write) begin
			if (write_last)
				fail_run("Write stayed high for more than one cycle");
			if (f2h_csr_readdata[full_bit])
				fail_run("Write issued while the transmit FIFO was full");
			if (cycle_count - write_cycle < 3)
				fail_run("Write pulses came less than three cycles apart");
			check_value(64'(expected_reply), 64'(f2h_cmd.writedata), "write data");
			write_cycle = cycle_count;
			if (stream_on && read_count < num_words)
				stream_writes++;
		end
		write_last = f2h_cmd.write;
		// Push words with random gaps
		if (stream_on && push_idx < num_words) begin
			if (gap_left == 0) begin
				rx_queue.push_back(words[push_idx]);
				push_idx++;
				gap_left = $urandom % 5;
			end else begin
				gap_left--;
			end
		end
		// Status levels
		h2f_csr_readdata            = '0;
		h2f_csr_readdata[empty_bit] = (rx_queue.size() == 0);
		f2h_csr_readdata            = '0;
		f2h_csr_readdata[full_bit]  = (tx_count >= tx_capacity);
	end

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		void'($urandom(seed));
		$readmemh("verification/fifo_bridge_tests.txt", tests_mem);
		num_words = int'(tests_mem[0]);
		if (num_words < 1 || num_words > 32)
			fail_run("Word count in the test file is out of range");
		for (int i = 0; i < num_words; i++)
			words[i] = tests_mem[1 + i];
		tx_capacity = int'(tests_mem[1 + num_words]);
		for (int d = 0; d < 16; d++)
			glyph[d] = tests_mem[2 + num_words + d][6:0];
		cycle_limit = 8 * num_words + 6 * tx_capacity + 200;

		// Receive FIFO starts empty and transmit FIFO full
		push_idx        = 0;
		gap_left        = 0;
		read_count      = 0;
		rise_cycle      = -100;
		display_due     = 0;
		tx_count        = tx_capacity;
		write_cycle     = -100;
		stream_writes   = 0;
		cycle_count     = 0;
		read_last       = 1'b0;
		write_last      = 1'b0;
		display_pending = 1'b0;
		stream_on       = 1'b0;
		drain_req       = 1'b0;
		expect_word     = '0;
		rst_n            = 1'b0;
		h2f_readdata     = '0;
		h2f_csr_readdata = '0;
		h2f_csr_readdata[empty_bit] = 1'b1;
		f2h_csr_readdata = '0;
		f2h_csr_readdata[full_bit]  = 1'b1;

		repeat (10) @(posedge CLOCK_50);
		#1;
		rst_n = 1'b1;

		// Quiet after reset with all digits at 0
		repeat (6) begin
			@(negedge CLOCK_50);
			check_value(64'd0, 64'(h2f_read), "read after reset");
			check_value(64'd0, 64'(f2h_cmd.write), "write after reset");
			check_value(64'(glyphs_of(32'h0)), 64'(hex), "digits after reset");
		end

		// Stream words in while the transmit FIFO fills
		@(negedge CLOCK_50);
		drain_req = 1'b1;
		stream_on = 1'b1;
		@(negedge CLOCK_50);
		while (read_count < num_words || display_pending || tx_count < tx_capacity)
			@(negedge CLOCK_50);
		check_value(64'd1, 64'(stream_writes > 0), "writes during receive stream");
		check_value(64'(glyphs_of(words[num_words-1])), 64'(hex), "final digits");

		// Held full so no write may start
		repeat (10) @(negedge CLOCK_50);

		// Drain and see writes fill it again
		drain_req = 1'b1;
		@(negedge CLOCK_50);
		@(negedge CLOCK_50);
		while (tx_count < tx_capacity)
			@(negedge CLOCK_50);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: verilog/bridge_pkg.sv
package bridge_pkg;

	// ==============================
	// FIFO words
	// ==============================

	// One Avalon data or status word of either FIFO
	typedef logic [31:0] word_t;

	// Status register bit positions
	// Bit 0 is set while the FIFO is full
	localparam int csr_full_bit = 0;
	// Bit 1 is set while the FIFO is empty
	localparam int csr_empty_bit = 1;

	// Fixed word sent back to the processor
	localparam word_t reply_word = 32'h007A_FB38;

	// ==============================
	// Bridge commands
	// ==============================

	// Write command toward the FPGA-to-HPS FIFO
	// FIFO takes writedata on the edge where write is high
	typedef struct packed {
		logic  write;
		word_t writedata;
	} f2h_write_t;

	// ==============================
	// Sequencer states
	// ==============================

	// HPS-to-FPGA read sequencer
	// Idle polls empty, wait drops the read, capture takes the word
	typedef enum logic [1:0] {
		h2f_idle,
		h2f_wait,
		h2f_capture
	} h2f_state_t;

	// FPGA-to-HPS write sequencer
	// Done is the single cycle after a write pulse
	typedef enum logic {
		f2h_idle,
		f2h_done
	} f2h_state_t;

endpackage

// File: verilog/display_pkg.sv
package display_pkg;

	// ==============================
	// Seven-segment display
	// ==============================

	// Digits on the board, HEX0 through HEX5
	localparam int num_digits = 6;

	// One hexadecimal digit
	typedef logic [3:0] nibble_t;

	// One digit's segments, active low
	// Segment a in bit 0 up to segment g in bit 6
	typedef logic [6:0] segments_t;

	// Value shown across all digits
	// Four bits per digit
	typedef logic [4*num_digits-1:0] display_word_t;

	// All digit patterns packed together
	// Element i drives digit i
	typedef segments_t [num_digits-1:0] hex_segments_t;

endpackage

// File: verilog/f2h_write_sequencer.sv
`timescale 1ns/1ps

module f2h_write_sequencer (
	input  logic                   CLOCK_50,
	input  logic                   rst_n,
	input  bridge_pkg::word_t      csr_status,
	output bridge_pkg::f2h_write_t cmd
);

	import bridge_pkg::*;

	// ==============================
	// State and reply buffer
	// ==============================

	f2h_state_t state;

	// One-word transmit buffer
	word_t buffer_q;
	logic  buffer_valid;

	// Status level, sampled every clock
	logic fifo_full;

	assign fifo_full = csr_status[csr_full_bit];

	// ==============================
	// Write FSM
	// ==============================

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			state         <= f2h_idle;
			cmd.write     <= 1'b0;
			cmd.writedata <= '0;
			buffer_q      <= '0;
			buffer_valid  <= 1'b0;
		end else begin
			case (state)
				f2h_idle: begin
					// Room in the FIFO and a word ready
					if (!fifo_full && buffer_valid) begin
						cmd.write     <= 1'b1;
						cmd.writedata <= buffer_q;
						state         <= f2h_done;
					end
				end
				default: begin
					// Single-cycle pulse, buffer consumed
					cmd.write    <= 1'b0;
					buffer_valid <= 1'b0;
					state        <= f2h_idle;
				end
			endcase

			// Refill once the buffer is empty
			if (!buffer_valid) begin
				buffer_q     <= reply_word;
				buffer_valid <= 1'b1;
			end
		end
	end

endmodule

// File: verilog/h2f_read_sequencer.sv
`timescale 1ns/1ps

module h2f_read_sequencer (
	input  logic                      CLOCK_50,
	input  logic                      rst_n,
	input  bridge_pkg::word_t         csr_status,
	input  bridge_pkg::word_t         readdata,
	output logic                      read,
	output display_pkg::display_word_t display_word
);

	import bridge_pkg::*;
	import display_pkg::*;

	// ==============================
	// State and buffers
	// ==============================

	h2f_state_t state;

	// One-word receive buffer
	word_t buffer_q;
	logic  buffer_valid;

	// Low digits of the last word taken from the buffer
	display_word_t display_q;

	// Status level sampled every clock
	logic fifo_empty;

	assign fifo_empty = csr_status[csr_empty_bit];

	// ==============================
	// Read FSM
	// ==============================

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			state        <= h2f_idle;
			read         <= 1'b0;
			buffer_q     <= '0;
			buffer_valid <= 1'b0;
			display_q    <= '0;
		end else begin
			// Buffer drains to the display one cycle after capture
			if (buffer_valid) begin
				// Only the low digits reach the display
				display_q    <= buffer_q[4*num_digits-1:0];
				buffer_valid <= 1'b0;
			end

			case (state)
				h2f_idle: begin
					// Data waiting and previous word already moved on
					if (!fifo_empty && !buffer_valid) begin
						read  <= 1'b1;
						state <= h2f_wait;
					end
				end
				h2f_wait: begin
					// Drop read before the word shows up
					read  <= 1'b0;
					state <= h2f_capture;
				end
				h2f_capture: begin
					// FIFO holds the head word on readdata now
					buffer_q     <= readdata;
					buffer_valid <= 1'b1;
					state        <= h2f_idle;
				end
				default: begin
					read  <= 1'b0;
					state <= h2f_idle;
				end
			endcase
		end
	end

	assign display_word = display_q;

endmodule

// File: verilog/hex_digit_decoder.sv
`timescale 1ns/1ps

module hex_digit_decoder (
	input  display_pkg::nibble_t   digit,
	output display_pkg::segments_t segments
);

	// ==============================
	// Glyph table
	// ==============================

	// Bit order g f e d c b a, zero lights a segment
	always_comb begin
		segments = 7'b111_1111;
		case (digit)
			4'h0: segments = 7'b100_0000;
			4'h1: segments = 7'b111_1001;
			4'h2: segments = 7'b010_0100;
			4'h3: segments = 7'b011_0000;
			4'h4: segments = 7'b001_1001;
			4'h5: segments = 7'b001_0010;
			4'h6: segments = 7'b000_0010;
			4'h7: segments = 7'b111_1000;
			4'h8: segments = 7'b000_0000;
			4'h9: segments = 7'b001_0000;
			// Upper-case A
			4'hA: segments = 7'b000_1000;
			// Lower-case b so it differs from 8
			4'hB: segments = 7'b000_0011;
			4'hC: segments = 7'b100_0110;
			// Lower-case d so it differs from 0
			4'hD: segments = 7'b010_0001;
			4'hE: segments = 7'b000_0110;
			4'hF: segments = 7'b000_1110;
			default: segments = 7'b111_1111;
		endcase
	end

endmodule

// File: verilog/hps_fifo_bridge_top.sv
`timescale 1ns/1ps

module hps_fifo_bridge_top (
	input  logic                       CLOCK_50,
	input  logic                       rst_n,

	// HPS-to-FPGA FIFO, Avalon output side
	input  bridge_pkg::word_t          h2f_csr_readdata,
	input  bridge_pkg::word_t          h2f_readdata,
	output logic                       h2f_read,

	// FPGA-to-HPS FIFO, Avalon input side
	input  bridge_pkg::word_t          f2h_csr_readdata,
	output bridge_pkg::f2h_write_t     f2h_cmd,

	// Seven-segment digits, HEX0 in element 0
	output display_pkg::hex_segments_t hex
);

	import display_pkg::*;

	// ==============================
	// Receive path
	// ==============================

	// Word shown on the digits
	display_word_t display_word;

	h2f_read_sequencer u_h2f_read_sequencer (
		.CLOCK_50     (CLOCK_50),
		.rst_n        (rst_n),
		.csr_status   (h2f_csr_readdata),
		.readdata     (h2f_readdata),
		.read         (h2f_read),
		.display_word (display_word)
	);

	// ==============================
	// Transmit path
	// ==============================

	// Runs on its own, independent of the receive side
	f2h_write_sequencer u_f2h_write_sequencer (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.csr_status (f2h_csr_readdata),
		.cmd        (f2h_cmd)
	);

	// ==============================
	// Digit decoders
	// ==============================

	// Digit i shows nibble i of the display word
	genvar i;
	generate
		for (i = 0; i < num_digits; i++) begin : g_digit
			hex_digit_decoder u_hex_digit_decoder (
				.digit    (display_word[4*i +: 4]),
				.segments (hex[i])
			);
		end
	endgenerate

endmodule
